//--- Bender.yml
package:
  name: timer_subsys

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/timer_pkg.sv
      - logic/timer_wb_ctrl.sv
      - logic/timer_compare_bank.sv
      - logic/timer_irq_status.sv
      - logic/timer_subsys_top.sv
  - target: test
    include_dirs:
      - logic
      - testbench
    files:
      - testbench/tb_timer_subsys.sv

//--- logic/timer_cfg.svh
`ifndef TIMER_CFG_SVH
`define TIMER_CFG_SVH

// Width of the Wishbone data bus and of every register
`define TIMER_DATA_W 32

// Word address width; the bus address covers byte address bits 5 to 2
`define TIMER_ADR_W 4

// Number of compare channels
// The address map reserves a two-bit channel index, so 1 to 4 are valid
`define TIMER_NUM_CHAN 4

`endif

//--- logic/timer_compare_bank.sv
`timescale 1ns/100ps

`include "timer_cfg.svh"

module timer_compare_bank (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [`TIMER_DATA_W-1:0]   wr_data_i,
  input  logic [`TIMER_DATA_W/8-1:0] wr_sel_i,
  input  logic                       cmp_we_i,
  input  logic                       cnt_we_i,
  input  logic [1:0]                 chan_idx_i,
  input  logic [`TIMER_NUM_CHAN-1:0] chan_en_i,
  output logic [`TIMER_DATA_W-1:0]   counter_o,
  output logic [`TIMER_DATA_W-1:0]   cmp_rd_o,
  output logic [`TIMER_DATA_W-1:0]   cnt_rd_o,
  output logic [`TIMER_NUM_CHAN-1:0] event_o
);

  logic [`TIMER_DATA_W-1:0] counter_q;
  logic [`TIMER_DATA_W-1:0] wr_mask;
  logic [`TIMER_DATA_W-1:0] cmp_q  [`TIMER_NUM_CHAN];
  logic [`TIMER_DATA_W-1:0] cnt_q  [`TIMER_NUM_CHAN];
  logic [`TIMER_DATA_W-1:0] cnt_d  [`TIMER_NUM_CHAN];

  assign wr_mask = timer_pkg::byte_mask(wr_sel_i);

  always_comb
  begin
    for (int i = 0; i < `TIMER_NUM_CHAN; i++)
    begin
      event_o[i] = chan_en_i[i] && (cmp_q[i] == counter_q);
    end
  end

  // An event in the same cycle as a software write counts on top of the written value
  always_comb
  begin
    for (int i = 0; i < `TIMER_NUM_CHAN; i++)
    begin
      cnt_d[i] = cnt_q[i];
      if (cnt_we_i && (chan_idx_i == i))
      begin
        cnt_d[i] = (cnt_q[i] & ~wr_mask) | (wr_data_i & wr_mask);
      end
      if (event_o[i])
      begin
        cnt_d[i] = cnt_d[i] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      counter_q <= '0;
      for (int i = 0; i < `TIMER_NUM_CHAN; i++)
      begin
        cmp_q[i] <= '0;
        cnt_q[i] <= '0;
      end
    end
    else
    begin
      counter_q <= counter_q + 1'b1;
      for (int i = 0; i < `TIMER_NUM_CHAN; i++)
      begin
        if (cmp_we_i && (chan_idx_i == i))
        begin
          cmp_q[i] <= (cmp_q[i] & ~wr_mask) | (wr_data_i & wr_mask);
        end
        cnt_q[i] <= cnt_d[i];
      end
    end
  end

  always_comb
  begin
    cmp_rd_o = '0;
    cnt_rd_o = '0;
    for (int i = 0; i < `TIMER_NUM_CHAN; i++)
    begin
      if (chan_idx_i == i)
      begin
        cmp_rd_o = cmp_q[i];
        cnt_rd_o = cnt_q[i];
      end
    end
  end

  assign counter_o = counter_q;

  a_no_event_disabled: assert property (
    @(posedge clk_i) disable iff (rst_i) (event_o & ~chan_en_i) == '0
  );

endmodule

//--- logic/timer_irq_status.sv
`timescale 1ns/100ps

`include "timer_cfg.svh"

module timer_irq_status (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [`TIMER_DATA_W-1:0]   wr_data_i,
  input  logic [`TIMER_DATA_W/8-1:0] wr_sel_i,
  input  logic                       status_we_i,
  input  logic [`TIMER_NUM_CHAN-1:0] event_i,
  input  logic [`TIMER_NUM_CHAN-1:0] irq_mask_i,
  output logic [`TIMER_DATA_W-1:0]   status_o,
  output logic [`TIMER_NUM_CHAN-1:0] irq_o
);

  logic [`TIMER_DATA_W-1:0] status_q;
  logic [`TIMER_DATA_W-1:0] status_d;

  always_comb
  begin
    status_d = status_q;
    // Software flips the bits it writes as ones in the selected bytes
    if (status_we_i)
    begin
      status_d = status_q ^ (wr_data_i & timer_pkg::byte_mask(wr_sel_i));
    end
    // Events are applied last so they win over a clearing write
    status_d[`TIMER_NUM_CHAN-1:0] = status_d[`TIMER_NUM_CHAN-1:0] | event_i;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      status_q <= '0;
    end
    else
    begin
      status_q <= status_d;
    end
  end

  assign status_o = status_q;
  assign irq_o    = status_q[`TIMER_NUM_CHAN-1:0] & irq_mask_i;

endmodule

//--- logic/timer_pkg.sv
`include "timer_cfg.svh"

package timer_pkg;

  // Wishbone classic slave sequencing
  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_BUSY,
    BUS_DONE
  } bus_state_e;

  // Register addressed by the current transfer
  typedef enum logic [2:0] {
    REG_CONTROL,
    REG_STATUS,
    REG_COMPARE,
    REG_EVCOUNT,
    REG_COUNTER,
    REG_NONE
  } reg_sel_e;

  // Expands byte selects into a bit mask over one data word
  function automatic logic [`TIMER_DATA_W-1:0] byte_mask(
    input logic [`TIMER_DATA_W/8-1:0] sel
  );
    logic [`TIMER_DATA_W-1:0] mask;
    for (int b = 0; b < `TIMER_DATA_W/8; b++)
    begin
      mask[8*b +: 8] = {8{sel[b]}};
    end
    return mask;
  endfunction

endpackage

//--- logic/timer_subsys_top.sv
`timescale 1ns/100ps

`include "timer_cfg.svh"

module timer_subsys_top (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [`TIMER_ADR_W-1:0]    wb_adr_i,
  input  logic [`TIMER_DATA_W/8-1:0] wb_sel_i,
  input  logic [`TIMER_DATA_W-1:0]   wb_dat_i,
  output logic [`TIMER_DATA_W-1:0]   wb_dat_o,
  output logic                       wb_ack_o,
  output logic [`TIMER_NUM_CHAN-1:0] irq_o
);

  logic [`TIMER_DATA_W-1:0]   counter;
  logic [`TIMER_DATA_W-1:0]   cmp_rd;
  logic [`TIMER_DATA_W-1:0]   cnt_rd;
  logic [`TIMER_DATA_W-1:0]   status;
  logic [`TIMER_DATA_W-1:0]   wr_data;
  logic [`TIMER_DATA_W/8-1:0] wr_sel;
  logic                       cmp_we;
  logic                       cnt_we;
  logic                       status_we;
  logic [1:0]                 chan_idx;
  logic [`TIMER_NUM_CHAN-1:0] chan_en;
  logic [`TIMER_NUM_CHAN-1:0] irq_mask;
  logic [`TIMER_NUM_CHAN-1:0] chan_event;

  timer_wb_ctrl i_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_sel_i    (wb_sel_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .counter_i   (counter),
    .cmp_rd_i    (cmp_rd),
    .cnt_rd_i    (cnt_rd),
    .status_i    (status),
    .wr_data_o   (wr_data),
    .wr_sel_o    (wr_sel),
    .cmp_we_o    (cmp_we),
    .cnt_we_o    (cnt_we),
    .status_we_o (status_we),
    .chan_idx_o  (chan_idx),
    .chan_en_o   (chan_en),
    .irq_mask_o  (irq_mask)
  );

  timer_compare_bank i_cmp (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wr_data_i  (wr_data),
    .wr_sel_i   (wr_sel),
    .cmp_we_i   (cmp_we),
    .cnt_we_i   (cnt_we),
    .chan_idx_i (chan_idx),
    .chan_en_i  (chan_en),
    .counter_o  (counter),
    .cmp_rd_o   (cmp_rd),
    .cnt_rd_o   (cnt_rd),
    .event_o    (chan_event)
  );

  timer_irq_status i_irq (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wr_data_i   (wr_data),
    .wr_sel_i    (wr_sel),
    .status_we_i (status_we),
    .event_i     (chan_event),
    .irq_mask_i  (irq_mask),
    .status_o    (status),
    .irq_o       (irq_o)
  );

endmodule

//--- logic/timer_wb_ctrl.sv
`timescale 1ns/100ps

`include "timer_cfg.svh"

module timer_wb_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [`TIMER_ADR_W-1:0]    wb_adr_i,
  input  logic [`TIMER_DATA_W/8-1:0] wb_sel_i,
  input  logic [`TIMER_DATA_W-1:0]   wb_dat_i,
  output logic [`TIMER_DATA_W-1:0]   wb_dat_o,
  output logic                       wb_ack_o,
  input  logic [`TIMER_DATA_W-1:0]   counter_i,
  input  logic [`TIMER_DATA_W-1:0]   cmp_rd_i,
  input  logic [`TIMER_DATA_W-1:0]   cnt_rd_i,
  input  logic [`TIMER_DATA_W-1:0]   status_i,
  output logic [`TIMER_DATA_W-1:0]   wr_data_o,
  output logic [`TIMER_DATA_W/8-1:0] wr_sel_o,
  output logic                       cmp_we_o,
  output logic                       cnt_we_o,
  output logic                       status_we_o,
  output logic [1:0]                 chan_idx_o,
  output logic [`TIMER_NUM_CHAN-1:0] chan_en_o,
  output logic [`TIMER_NUM_CHAN-1:0] irq_mask_o
);

  timer_pkg::bus_state_e    state_q;
  timer_pkg::bus_state_e    state_d;
  timer_pkg::reg_sel_e      reg_sel;

  logic                     chan_valid;
  logic                     wr_en;
  logic                     rd_en;
  logic [`TIMER_DATA_W-1:0] wr_mask;
  logic [`TIMER_DATA_W-1:0] control_q;
  logic [`TIMER_DATA_W-1:0] rd_data;
  logic [`TIMER_DATA_W-1:0] result_q;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      timer_pkg::BUS_IDLE:
      begin
        if (wb_cyc_i && wb_stb_i)
        begin
          state_d = timer_pkg::BUS_BUSY;
        end
      end
      timer_pkg::BUS_BUSY:
      begin
        state_d = timer_pkg::BUS_DONE;
      end
      default:
      begin
        state_d = timer_pkg::BUS_IDLE;
      end
    endcase
  end

  // Channel registers beyond the configured count decode as unmapped
  assign chan_valid = (wb_adr_i[1:0] < `TIMER_NUM_CHAN);

  always_comb
  begin
    reg_sel = timer_pkg::REG_NONE;
    case (wb_adr_i[3:2])
      2'd0:
      begin
        if (wb_adr_i[1:0] == 2'd0)
        begin
          reg_sel = timer_pkg::REG_CONTROL;
        end
        else if (wb_adr_i[1:0] == 2'd1)
        begin
          reg_sel = timer_pkg::REG_STATUS;
        end
      end
      2'd1:
      begin
        if (chan_valid)
        begin
          reg_sel = timer_pkg::REG_COMPARE;
        end
      end
      2'd2:
      begin
        if (chan_valid)
        begin
          reg_sel = timer_pkg::REG_EVCOUNT;
        end
      end
      default:
      begin
        if (wb_adr_i[1:0] == 2'd0)
        begin
          reg_sel = timer_pkg::REG_COUNTER;
        end
      end
    endcase
  end

  // The transfer acts only while the request is still presented in BUS_BUSY
  assign wr_en = (state_q == timer_pkg::BUS_BUSY) && wb_cyc_i && wb_stb_i && wb_we_i;
  assign rd_en = (state_q == timer_pkg::BUS_BUSY) && wb_cyc_i && wb_stb_i && !wb_we_i;

  assign cmp_we_o    = wr_en && (reg_sel == timer_pkg::REG_COMPARE);
  assign cnt_we_o    = wr_en && (reg_sel == timer_pkg::REG_EVCOUNT);
  assign status_we_o = wr_en && (reg_sel == timer_pkg::REG_STATUS);

  assign wr_data_o  = wb_dat_i;
  assign wr_sel_o   = wb_sel_i;
  assign chan_idx_o = wb_adr_i[1:0];
  assign wr_mask    = timer_pkg::byte_mask(wb_sel_i);

  always_comb
  begin
    case (reg_sel)
      timer_pkg::REG_CONTROL: rd_data = control_q;
      timer_pkg::REG_STATUS:  rd_data = status_i;
      timer_pkg::REG_COMPARE: rd_data = cmp_rd_i;
      timer_pkg::REG_EVCOUNT: rd_data = cnt_rd_i;
      timer_pkg::REG_COUNTER: rd_data = counter_i;
      default:                rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q   <= timer_pkg::BUS_IDLE;
      control_q <= '0;
      result_q  <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (wr_en && (reg_sel == timer_pkg::REG_CONTROL))
      begin
        control_q <= (control_q & ~wr_mask) | (wb_dat_i & wr_mask);
      end
      if (rd_en)
      begin
        result_q <= rd_data;
      end
    end
  end

  // Enables sit in the low nibble and masks start at bit 4
  assign chan_en_o  = control_q[`TIMER_NUM_CHAN-1:0];
  assign irq_mask_o = control_q[4 +: `TIMER_NUM_CHAN];

  assign wb_ack_o = (state_q == timer_pkg::BUS_DONE);
  assign wb_dat_o = result_q;

  // A transfer always passes through idle, so ack cannot repeat back to back
  a_ack_single: assert property (
    @(posedge clk_i) disable iff (rst_i) wb_ack_o |=> !wb_ack_o
  );

  // Only one datapath target is written per transfer
  a_one_strobe: assert property (
    @(posedge clk_i) disable iff (rst_i) $onehot0({cmp_we_o, cnt_we_o, status_we_o})
  );

endmodule

//--- sim.f
+incdir+logic
+incdir+testbench
logic/timer_pkg.sv
logic/timer_wb_ctrl.sv
logic/timer_compare_bank.sv
logic/timer_irq_status.sv
logic/timer_subsys_top.sv
testbench/tb_timer_subsys.sv

//--- testbench/tb_timer_tasks.svh
`ifndef TB_TIMER_TASKS_SVH
`define TB_TIMER_TASKS_SVH

// Reference model of a byte-select write
function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                            input logic [31:0] new_val,
                                            input logic [3:0]  sel);
  logic [31:0] result;
  result = old_val;
  for (int b = 0; b < 4; b++)
  begin
    if (sel[b])
    begin
      result[8*b +: 8] = new_val[8*b +: 8];
    end
  end
  return result;
endfunction

task automatic check_equal(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (expected !== actual)
  begin
    $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    error_count++;
  end
endtask

task automatic report_test(input string name, input int errors_before);
  test_count++;
  if (error_count == errors_before)
  begin
    $display("%s: ok", name);
  end
  else
  begin
    failed_tests++;
    $display("%s: failed with %0d errors", name, error_count - errors_before);
  end
endtask

task automatic wait_ack(input logic [3:0] adr);
  int cycles;
  cycles = 0;
  @(negedge clk);
  while (!wb_ack && cycles < ACK_LIMIT)
  begin
    @(negedge clk);
    cycles++;
  end
  if (!wb_ack)
  begin
    $display("No acknowledge from word address %0d within %0d cycles", adr, ACK_LIMIT);
    error_count++;
  end
endtask

task automatic wb_write(input logic [3:0] adr, input logic [3:0] sel, input logic [31:0] data);
  @(negedge clk);
  wb_cyc   = 1'b1;
  wb_stb   = 1'b1;
  wb_we    = 1'b1;
  wb_adr   = adr;
  wb_sel   = sel;
  wb_wdata = data;
  wait_ack(adr);
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
  wb_we  = 1'b0;
endtask

task automatic wb_read(input logic [3:0] adr, output logic [31:0] data);
  @(negedge clk);
  wb_cyc = 1'b1;
  wb_stb = 1'b1;
  wb_we  = 1'b0;
  wb_adr = adr;
  wb_sel = 4'hF;
  wait_ack(adr);
  data   = wb_rdata;
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
endtask

// Polls status over the bus until bit n is set
task automatic wait_status(input int n, output logic seen);
  logic [31:0] got;
  int          polls;
  seen  = 1'b0;
  polls = 0;
  while (!seen && polls < POLL_LIMIT)
  begin
    wb_read(ADR_STATUS, got);
    seen = got[n];
    polls++;
  end
  if (!seen)
  begin
    $display("Status bit %0d was not set within %0d status reads", n, POLL_LIMIT);
    error_count++;
  end
endtask

task automatic readback_bytes();
  int          errors_before;
  logic [3:0]  adr;
  logic [3:0]  sel;
  logic [31:0] old_val;
  logic [31:0] new_val;
  logic [31:0] got;
  errors_before = error_count;
  for (int i = 0; i < 16; i++)
  begin
    adr     = ((i & 4) != 0 ? ADR_EVCOUNT : ADR_COMPARE) + 4'(i % 4);
    sel     = 4'($urandom);
    new_val = $urandom;
    wb_read(adr, old_val);
    wb_write(adr, sel, new_val);
    wb_read(adr, got);
    check_equal("readback_bytes", merge_bytes(old_val, new_val, sel), got);
  end
  report_test("readback_bytes", errors_before);
endtask

task automatic status_and_decode();
  int          errors_before;
  logic [31:0] orig;
  logic [31:0] pattern;
  logic [31:0] got;
  logic [31:0] snap [12];
  errors_before = error_count;
  pattern       = $urandom;
  wb_read(ADR_STATUS, orig);
  wb_write(ADR_STATUS, 4'hF, pattern);
  wb_read(ADR_STATUS, got);
  check_equal("status_and_decode toggle once", orig ^ pattern, got);
  wb_write(ADR_STATUS, 4'hF, pattern);
  wb_read(ADR_STATUS, got);
  check_equal("status_and_decode toggle twice", orig, got);
  for (int a = 0; a < 12; a++)
  begin
    if (a != 2 && a != 3)
    begin
      wb_read(4'(a), snap[a]);
    end
  end
  // Word addresses 2, 3 and 13 to 15 hold nothing
  for (int a = 2; a < 16; a++)
  begin
    if (a < 4 || a > 12)
    begin
      wb_write(4'(a), 4'hF, $urandom);
      wb_read(4'(a), got);
      check_equal("status_and_decode unmapped read", 32'h0, got);
    end
  end
  for (int a = 0; a < 12; a++)
  begin
    if (a != 2 && a != 3)
    begin
      wb_read(4'(a), got);
      check_equal("status_and_decode unmapped write side effect", snap[a], got);
    end
  end
  report_test("status_and_decode", errors_before);
endtask

task automatic counter_runs();
  int          errors_before;
  logic [31:0] first;
  logic [31:0] second;
  errors_before = error_count;
  wb_read(ADR_COUNTER, first);
  wb_read(ADR_COUNTER, second);
  // Back to back transfers are at least three cycles apart
  check_equal("counter_runs advance", 32'd1,
              32'((second > first) && (second - first >= 3)));
  report_test("counter_runs", errors_before);
endtask

task automatic compare_match(input int n);
  int          errors_before;
  string       name;
  logic [31:0] count_before;
  logic [31:0] now;
  logic [31:0] got;
  logic        seen;
  errors_before = error_count;
  name          = $sformatf("compare_match ch%0d", n);
  wb_read(ADR_EVCOUNT + 4'(n), count_before);
  wb_read(ADR_COUNTER, now);
  wb_write(ADR_COMPARE + 4'(n), 4'hF, now + 200 + ($urandom % 201));
  wb_write(ADR_CONTROL, 4'h1, 32'(1) << n);
  wait_status(n, seen);
  wb_read(ADR_EVCOUNT + 4'(n), got);
  check_equal($sformatf("%s event count", name), count_before + 1, got);
  wb_read(ADR_STATUS, got);
  check_equal($sformatf("%s status", name), 32'(1) << n, got);
  wb_write(ADR_CONTROL, 4'h1, 32'h0);
  wb_write(ADR_STATUS, 4'hF, 32'(1) << n);
  report_test(name, errors_before);
endtask

task automatic irq_masking(input int n);
  int          errors_before;
  logic [31:0] now;
  logic [31:0] got;
  logic        seen;
  errors_before = error_count;
  wb_read(ADR_COUNTER, now);
  wb_write(ADR_COMPARE + 4'(n), 4'hF, now + 200 + ($urandom % 201));
  wb_write(ADR_CONTROL, 4'h1, 32'(1) << n);
  wait_status(n, seen);
  check_equal("irq_masking masked line", 32'h0, 32'(irq));
  wb_write(ADR_CONTROL, 4'h1, (32'(1) << n) | (32'(1) << (n + 4)));
  wb_read(ADR_STATUS, got);
  check_equal("irq_masking status", 32'(1) << n, got);
  check_equal("irq_masking unmasked line", 32'(1) << n, 32'(irq));
  wb_write(ADR_STATUS, 4'hF, 32'(1) << n);
  check_equal("irq_masking line after toggle", 32'h0, 32'(irq));
  wb_write(ADR_CONTROL, 4'h1, 32'h0);
  report_test("irq_masking", errors_before);
endtask

task automatic disabled_channel(input int n);
  int          errors_before;
  int          polls;
  logic [31:0] count_before;
  logic [31:0] target;
  logic [31:0] got;
  errors_before = error_count;
  // All other channels run and their compare values already lie behind the counter
  wb_write(ADR_CONTROL, 4'h1, 32'hF & ~(32'(1) << n));
  wb_read(ADR_EVCOUNT + 4'(n), count_before);
  wb_read(ADR_COUNTER, got);
  target = got + 100;
  wb_write(ADR_COMPARE + 4'(n), 4'hF, target);
  polls = 0;
  while (got <= target + 100 && polls < POLL_LIMIT)
  begin
    wb_read(ADR_COUNTER, got);
    polls++;
  end
  if (got <= target + 100)
  begin
    $display("Counter did not pass the compare value within %0d reads", POLL_LIMIT);
    error_count++;
  end
  wb_read(ADR_STATUS, got);
  check_equal("disabled_channel status", 32'h0, got);
  wb_read(ADR_EVCOUNT + 4'(n), got);
  check_equal("disabled_channel event count", count_before, got);
  wb_write(ADR_CONTROL, 4'h1, 32'h0);
  report_test("disabled_channel", errors_before);
endtask

`endif

//--- testbench/tb_timer_subsys.sv
`timescale 1ns/100ps

`include "timer_cfg.svh"

module tb_timer_subsys;

  // Word addresses of the register map
  localparam logic [3:0] ADR_CONTROL = 4'd0;
  localparam logic [3:0] ADR_STATUS  = 4'd1;
  localparam logic [3:0] ADR_COMPARE = 4'd4;
  localparam logic [3:0] ADR_EVCOUNT = 4'd8;
  localparam logic [3:0] ADR_COUNTER = 4'd12;

  localparam int ACK_LIMIT  = 16;
  localparam int POLL_LIMIT = 250;

  logic                       clk;
  logic                       rst;
  logic                       wb_cyc;
  logic                       wb_stb;
  logic                       wb_we;
  logic [`TIMER_ADR_W-1:0]    wb_adr;
  logic [`TIMER_DATA_W/8-1:0] wb_sel;
  logic [`TIMER_DATA_W-1:0]   wb_wdata;
  logic [`TIMER_DATA_W-1:0]   wb_rdata;
  logic                       wb_ack;
  logic [`TIMER_NUM_CHAN-1:0] irq;

  int          error_count;
  int          test_count;
  int          failed_tests;
  int unsigned seed_draw;

  timer_subsys_top i_dut (
    .clk_i    (clk),
    .rst_i    (rst),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_sel_i (wb_sel),
    .wb_dat_i (wb_wdata),
    .wb_dat_o (wb_rdata),
    .wb_ack_o (wb_ack),
    .irq_o    (irq)
  );

  `include "tb_timer_tasks.svh"

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #20 clk = ~clk;
    end
  end

  initial
  begin
    rst          = 1'b1;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_sel       = '0;
    wb_wdata     = '0;
    error_count  = 0;
    test_count   = 0;
    failed_tests = 0;
    seed_draw    = $urandom(32'h631f);

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    readback_bytes();
    status_and_decode();
    counter_runs();
    for (int n = 0; n < 4; n++)
    begin
      compare_match(n);
    end
    irq_masking(2);
    disabled_channel(1);

    $display("Tests: %0d run, %0d failed, %0d check errors",
             test_count, failed_tests, error_count);
    if (error_count == 0)
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
